// ==== hydra.f ====
+incdir+source
source/hydra_pkg.sv
source/xfer_if.sv
source/port_wr_frontend.sv
source/port_wr_sram_matcher.sv
source/sram_bank_xbar.sv
source/sram_interface.sv
source/hydra_apb_regs.sv
source/hydra.sv
dv/hydra_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the hydra testbench with Verilator, runs it and checks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f hydra.f --top-module hydra_tb -o hydra_sim

out=$(./obj_dir/hydra_sim 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation PASSED"

// ==== dv/hydra_tb.sv ====
`include "hydra_cfg.svh"

module hydra_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import hydra_pkg::*;

    logic clk, rst_n;
    logic [`HYDRA_PORTS-1:0] wr_sop, wr_eop, wr_vld;
    word_t wr_data [`HYDRA_PORTS];
    logic full, almost_full;
    logic psel, penable, pwrite, pready;
    logic [15:0] paddr;
    logic [31:0] pwdata, prdata;

    logic [31:0] lfsr;
    match_mode_t cur_mode;
    int cur_thresh;
    int exp_free [`HYDRA_BANKS];
    int exp_cnt [`HYDRA_BANKS][`HYDRA_PORTS];
    int free_now [`HYDRA_BANKS];
    word_t sent_w [64][256];   // Every packet sent, word 0 is the header
    int sent_len [64];
    int sent_port [64];
    int sent_dest [64];
    logic sent_hit [64];
    int npkt;

    hydra u_hydra (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .full(full), .almost_full(almost_full),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int rand_len();
        return 2 + int'(rand_bits(4)) % 11;
    endfunction

    function automatic logic [15:0] stat_addr(input int b, input int w);
        return 16'(16'h0100 + b * 32 + w * 4);
    endfunction

    function automatic logic [15:0] mem_addr(input int b, input int a);
        return 16'(16'h1000 + b * 16'h400 + a * 4);
    endfunction

    // Lowest eligible bank wins unless the mode finds a strictly better one
    function automatic int pick_bank(input int len, input int dest);
        int best;
        best = -1;
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            if (exp_free[b] - len >= cur_thresh) begin
                if (best < 0) begin
                    best = b;
                end else if (cur_mode == MATCH_MOST_FREE && exp_free[b] > exp_free[best]) begin
                    best = b;
                end else if (cur_mode == MATCH_FEWEST_DEST
                             && exp_cnt[b][dest] < exp_cnt[best][dest]) begin
                    best = b;
                end
            end
        end
        return best;
    endfunction

    task automatic fail_and_stop(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else
            fail_and_stop($sformatf("Fail at time %0t: %s read 0x%0h, expected 0x%0h",
                                    $time, what, got, exp));
    endtask

    task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int t;
        @(posedge clk);
        #2;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        t = 0;
        @(negedge clk);
        while (pready !== 1'b1) begin
            assert (t < 16) else fail_and_stop("Timeout waiting for pready on the APB bus");
            t++;
            @(negedge clk);
        end
        rdata = prdata;
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata);
        apb_access(1'b0, addr, '0, rdata);
    endtask

    task automatic set_control(input match_mode_t mode, input int thresh);
        logic [31:0] val;
        logic [31:0] d;
        val = {23'd0, 5'(thresh), 2'd0, 2'(mode)};
        cur_mode = mode;
        cur_thresh = thresh;
        apb_access(1'b1, 16'h0000, val, d);
        apb_read(16'h0000, d);
        check_val(d, val, "control register");
    endtask

    task automatic check_bank(input int b);
        logic [31:0] d;
        apb_read(stat_addr(b, 0), d);
        check_val(d, 32'(exp_free[b]), $sformatf("bank %0d free space", b));
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            apb_read(stat_addr(b, p + 1), d);
            check_val(d, 32'(exp_cnt[b][p]), $sformatf("bank %0d count for dest %0d", b, p));
        end
    endtask

    task automatic poll_word(input int b, input int a, input word_t mask, input word_t want,
                             output word_t got);
        logic [31:0] d;
        int t;
        t = 0;
        apb_read(mem_addr(b, a), d);
        while ((d[15:0] & mask) !== want) begin
            assert (t < 400) else
                fail_and_stop($sformatf("Timeout waiting for bank %0d address %0d, last read %h",
                                        b, a, d[15:0]));
            t++;
            apb_read(mem_addr(b, a), d);
        end
        got = d[15:0];
    endtask

    task automatic build_packet(input int port, input int len, input int dest, output int k);
        k = npkt;
        npkt++;
        sent_len[k] = len;
        sent_port[k] = port;
        sent_dest[k] = dest;
        sent_hit[k] = 1'b0;
        sent_w[k][0] = {9'(len), 3'b000, 4'(dest)};
        sent_w[k][1] = {4'ha, 2'(port), 2'b00, 8'(k)};   // Tag word names the packet
        for (int i = 2; i < len; i++) begin
            sent_w[k][i] = 16'(rand_bits(16));
        end
    endtask

    task automatic drive_packet(input int p, input int k);
        for (int i = 0; i < sent_len[k]; i++) begin
            @(posedge clk);
            #2;
            wr_vld[p] = 1'b1;
            wr_sop[p] = (i == 0);
            wr_eop[p] = (i == sent_len[k] - 1);
            wr_data[p] = sent_w[k][i];
        end
        @(posedge clk);
        #2;
        wr_vld[p] = 1'b0;
        wr_sop[p] = 1'b0;
        wr_eop[p] = 1'b0;
    endtask

    task automatic drive_port(input int p, input int first);
        for (int k = first; k < npkt; k++) begin
            if (sent_port[k] == p) begin
                drive_packet(p, k);
            end
        end
    endtask

    task automatic send_and_check(input int port, input int len, input int dest, input int want);
        int k, b, base;
        word_t w;
        build_packet(port, len, dest, k);
        b = pick_bank(len, dest);
        assert (b >= 0 && (want < 0 || b == want)) else
            fail_and_stop($sformatf("Fail at time %0t: model picks bank %0d, expected bank %0d",
                                    $time, b, want));
        drive_packet(port, k);
        base = `HYDRA_BANK_WORDS - exp_free[b];
        for (int i = 0; i < len; i++) begin
            poll_word(b, base + i, 16'hffff, sent_w[k][i], w);
        end
        exp_free[b] -= len;
        exp_cnt[b][dest]++;
        check_bank(b);
    endtask

    task automatic wait_consumed(input int total);
        logic [31:0] d;
        int used, t;
        used = -1;
        t = 0;
        while (used != total) begin
            assert (t < 200) else fail_and_stop("Timeout waiting for the parallel packets to land");
            t++;
            used = 0;
            for (int b = 0; b < `HYDRA_BANKS; b++) begin
                apb_read(stat_addr(b, 0), d);
                free_now[b] = int'(d);
                used += exp_free[b] - free_now[b];
            end
        end
    endtask

    // Walks the new packets of one bank header by header, so interleaving shows up as a mismatch
    task automatic parse_bank(input int b);
        logic [31:0] d;
        word_t w;
        int addr, k;
        addr = `HYDRA_BANK_WORDS - exp_free[b];
        while (addr < `HYDRA_BANK_WORDS - free_now[b]) begin
            apb_read(mem_addr(b, addr), d);
            poll_word(b, addr + 1, 16'hf000, 16'ha000, w);
            k = int'(w[7:0]);
            assert (k < npkt && !sent_hit[k] && d[15:0] === sent_w[k][0]) else
                fail_and_stop($sformatf("Fail at time %0t: bank %0d address %0d header %h tag %h",
                                        $time, b, addr, d[15:0], w));
            sent_hit[k] = 1'b1;
            for (int i = 2; i < sent_len[k]; i++) begin
                poll_word(b, addr + i, 16'hffff, sent_w[k][i], w);
            end
            exp_cnt[b][sent_dest[k]]++;
            addr += sent_len[k];
        end
        assert (addr == `HYDRA_BANK_WORDS - free_now[b]) else
            fail_and_stop($sformatf("Fail at time %0t: bank %0d packets end at %0d, space says %0d",
                                    $time, b, addr, `HYDRA_BANK_WORDS - free_now[b]));
        exp_free[b] = free_now[b];
        check_bank(b);
    endtask

    initial begin
        logic [31:0] d;
        int len, dest, dest0, first, k, total;
        lfsr = 32'h21143c69;
        npkt = 0;
        rst_n = 1'b0;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            wr_data[p] = '0;
        end
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        cur_mode = MATCH_FIRST_FIT;
        cur_thresh = 0;
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            exp_free[b] = `HYDRA_BANK_WORDS;
            for (int p = 0; p < `HYDRA_PORTS; p++) begin
                exp_cnt[b][p] = 0;
            end
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        @(negedge clk);
        assert (full === 1'b0 && almost_full === 1'b0) else
            fail_and_stop($sformatf("Fail at time %0t: full %b almost_full %b after reset",
                                    $time, full, almost_full));
        apb_read(16'h0004, d);
        check_val(d, 32'h0, "flag register");
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            check_bank(b);
        end

        // First fit into an empty switch, then the two other modes with the same dest
        dest0 = int'(rand_bits(2));
        len = rand_len();
        send_and_check(0, len, dest0, 0);
        set_control(MATCH_MOST_FREE, 0);
        len = rand_len();
        send_and_check(1, len, dest0, -1);
        set_control(MATCH_FEWEST_DEST, 0);
        len = rand_len();
        send_and_check(2, len, dest0, 2);

        // Leave bank 0 with 20 free words so a threshold of 20 shuts it
        set_control(MATCH_FIRST_FIT, 0);
        dest = int'(rand_bits(2));
        send_and_check(3, exp_free[0] - 20, dest, 0);
        set_control(MATCH_FIRST_FIT, 20);
        len = rand_len();
        dest = int'(rand_bits(2));
        send_and_check(0, len, dest, 1);

        set_control(MATCH_FIRST_FIT, 0);
        first = npkt;
        total = 0;
        for (int i = 0; i < 12; i++) begin
            len = rand_len();
            dest = int'(rand_bits(2));
            build_packet(i % `HYDRA_PORTS, len, dest, k);
            total += len;
        end
        fork
            drive_port(0, first);
            drive_port(1, first);
            drive_port(2, first);
            drive_port(3, first);
        join
        wait_consumed(total);
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            parse_bank(b);
        end
        for (int i = first; i < npkt; i++) begin
            assert (sent_hit[i]) else
                fail_and_stop($sformatf("Packet %0d from port %0d was not found in any bank",
                                        i, sent_port[i]));
        end

        // Close every bank at the top threshold, then jam port 0 behind an unplaceable header
        set_control(MATCH_FIRST_FIT, 31);
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            if (exp_free[b] - 31 >= 2) begin
                dest = int'(rand_bits(2));
                send_and_check(0, exp_free[b] - 31, dest, b);
            end
        end
        for (int n = 1; n <= `HYDRA_FIFO_DEPTH; n++) begin
            @(posedge clk);
            #2;
            wr_vld[0] = 1'b1;
            wr_sop[0] = (n == 1);
            wr_data[0] = (n == 1) ? 16'h0600 : 16'(rand_bits(16));   // Header of 12 words for dest 0
            @(posedge clk);
            #2;
            wr_vld[0] = 1'b0;
            wr_sop[0] = 1'b0;
            @(negedge clk);
            assert (almost_full === (n >= `HYDRA_AFULL_LEVEL)
                    && full === (n >= `HYDRA_FIFO_DEPTH)) else
                fail_and_stop($sformatf("Fail at time %0t: %0d words in, almost_full %b full %b",
                                        $time, n, almost_full, full));
        end
        apb_read(16'h0004, d);
        check_val(d, 32'h3, "flag register");

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== source/hydra.sv ====
`include "hydra_cfg.svh"

module hydra (
    input logic clk,
    input logic rst_n,
    input logic [`HYDRA_PORTS-1:0] wr_sop,
    input logic [`HYDRA_PORTS-1:0] wr_eop,
    input logic [`HYDRA_PORTS-1:0] wr_vld,
    input hydra_pkg::word_t wr_data [`HYDRA_PORTS],
    output logic full,
    output logic almost_full,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [15:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready
);
    import hydra_pkg::*;

    match_mode_t match_mode;
    thresh_t match_threshold;
    space_t free_space [`HYDRA_BANKS];
    pkt_cnt_t dest_cnt [`HYDRA_BANKS][`HYDRA_PORTS];
    logic [`HYDRA_BANKS-1:0] busy, bank_vld, bank_eop;
    word_t bank_data [`HYDRA_BANKS];
    logic [`HYDRA_PORTS-1:0] req, gnt, fifo_full, fifo_afull;
    bank_idx_t req_bank [`HYDRA_PORTS];
    bank_addr_t rd_addr;
    bank_idx_t rd_bank;
    word_t rd_data [`HYDRA_BANKS];

    xfer_if xfer [`HYDRA_PORTS] ();

    assign full = |fifo_full;
    assign almost_full = |fifo_afull;

    for (genvar p = 0; p < `HYDRA_PORTS; p++) begin : g_port
        logic match_enable, match_end;
        port_idx_t new_dest_port;
        pkt_len_t new_length;

        port_wr_frontend u_frontend (
            .clk(clk), .rst_n(rst_n),
            .wr_sop(wr_sop[p]), .wr_eop(wr_eop[p]), .wr_vld(wr_vld[p]), .wr_data(wr_data[p]),
            .xfer(xfer[p]),
            .match_enable(match_enable), .new_dest_port(new_dest_port),
            .new_length(new_length), .match_end(match_end),
            .fifo_full(fifo_full[p]), .fifo_afull(fifo_afull[p])
        );

        port_wr_sram_matcher u_matcher (
            .clk(clk), .rst_n(rst_n),
            .match_mode(match_mode), .match_threshold(match_threshold),
            .match_enable(match_enable), .new_dest_port(new_dest_port),
            .new_length(new_length),
            .free_space(free_space), .busy(busy), .dest_cnt(dest_cnt),
            .req(req[p]), .req_bank(req_bank[p]), .gnt(gnt[p]), .match_end(match_end)
        );
    end

    sram_bank_xbar u_xbar (
        .clk(clk), .rst_n(rst_n),
        .req(req), .req_bank(req_bank), .gnt(gnt), .xfer(xfer),
        .bank_vld(bank_vld), .bank_data(bank_data), .bank_eop(bank_eop), .busy(busy)
    );

    for (genvar b = 0; b < `HYDRA_BANKS; b++) begin : g_bank
        bank_addr_t bank_rd_addr;

        assign bank_rd_addr = (rd_bank == bank_idx_t'(b)) ? rd_addr : '0;   // Idle banks hold address 0

        sram_interface u_bank (
            .clk(clk), .rst_n(rst_n),
            .wr_vld(bank_vld[b]), .wr_data(bank_data[b]), .wr_eop(bank_eop[b]),
            .rd_addr(bank_rd_addr), .rd_data(rd_data[b]),
            .free_space(free_space[b]), .dest_cnt(dest_cnt[b])
        );
    end

    hydra_apb_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .match_mode(match_mode), .match_threshold(match_threshold),
        .full(full), .almost_full(almost_full),
        .free_space(free_space), .dest_cnt(dest_cnt),
        .rd_addr(rd_addr), .rd_bank(rd_bank), .rd_data(rd_data)
    );

endmodule

// ==== source/hydra_apb_regs.sv ====
`include "hydra_cfg.svh"

module hydra_apb_regs (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [15:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output hydra_pkg::match_mode_t match_mode,
    output hydra_pkg::thresh_t match_threshold,
    input logic full,
    input logic almost_full,
    input hydra_pkg::space_t free_space [`HYDRA_BANKS],
    input hydra_pkg::pkt_cnt_t dest_cnt [`HYDRA_BANKS][`HYDRA_PORTS],
    output hydra_pkg::bank_addr_t rd_addr,
    output hydra_pkg::bank_idx_t rd_bank,
    input hydra_pkg::word_t rd_data [`HYDRA_BANKS]
);
    import hydra_pkg::*;

    logic [15:0] mem_off;
    logic is_mem;
    bank_idx_t stat_bank;
    logic [2:0] stat_word;

    assign pready = 1'b1;

    // Memory window starts at 0x1000 with 0x400 bytes per bank
    assign mem_off = paddr - 16'h1000;
    assign is_mem = paddr >= 16'h1000 && mem_off < 16'(`HYDRA_BANKS * 'h400);
    assign rd_bank = mem_off[12:10];
    assign rd_addr = mem_off[9:2];   // Bank registers this on the setup-phase edge

    assign stat_bank = paddr[7:5];
    assign stat_word = paddr[4:2];

    always_comb begin
        prdata = '0;
        if (is_mem) begin
            prdata = {16'd0, rd_data[rd_bank]};
        end else if (paddr[15:8] == 8'h01) begin
            if (stat_word == 3'd0) begin
                prdata = {23'd0, free_space[stat_bank]};
            end else if (stat_word <= 3'd4) begin
                prdata = {23'd0, dest_cnt[stat_bank][port_idx_t'(stat_word - 3'd1)]};
            end
        end else if (paddr == 16'h0000) begin
            prdata = {23'd0, match_threshold, 2'd0, match_mode};
        end else if (paddr == 16'h0004) begin
            prdata = {30'd0, almost_full, full};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_mode <= MATCH_FIRST_FIT;
            match_threshold <= '0;
        end else if (psel && penable && pwrite && paddr == 16'h0000) begin
            match_mode <= match_mode_t'(pwdata[1:0]);
            match_threshold <= pwdata[8:4];
        end
    end

endmodule

// ==== source/sram_interface.sv ====
`include "hydra_cfg.svh"

module sram_interface (
    input logic clk,
    input logic rst_n,
    input logic wr_vld,
    input hydra_pkg::word_t wr_data,
    input logic wr_eop,
    input hydra_pkg::bank_addr_t rd_addr,
    output hydra_pkg::word_t rd_data,
    output hydra_pkg::space_t free_space,
    output hydra_pkg::pkt_cnt_t dest_cnt [`HYDRA_PORTS]
);
    import hydra_pkg::*;

    word_t mem [`HYDRA_BANK_WORDS];
    bank_addr_t wr_ptr;
    logic at_sop;   // Next word written is a header
    port_idx_t hdr_dest;
    pkt_len_t hdr_len;

    assign hdr_dest = wr_data[1:0];
    assign hdr_len = wr_data[15:7];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            at_sop <= 1'b1;
            free_space <= space_t'(`HYDRA_BANK_WORDS);
            for (int d = 0; d < `HYDRA_PORTS; d++) begin
                dest_cnt[d] <= '0;
            end
        end else if (wr_vld) begin
            wr_ptr <= wr_ptr + 1'b1;
            at_sop <= wr_eop;
            if (at_sop) begin
                free_space <= free_space - hdr_len;   // Whole packet is reserved on its header
                dest_cnt[hdr_dest] <= dest_cnt[hdr_dest] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            mem[wr_ptr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== source/sram_bank_xbar.sv ====
`include "hydra_cfg.svh"

module sram_bank_xbar (
    input logic clk,
    input logic rst_n,
    input logic [`HYDRA_PORTS-1:0] req,
    input hydra_pkg::bank_idx_t req_bank [`HYDRA_PORTS],
    output logic [`HYDRA_PORTS-1:0] gnt,
    xfer_if.xbar xfer [`HYDRA_PORTS],
    output logic [`HYDRA_BANKS-1:0] bank_vld,
    output hydra_pkg::word_t bank_data [`HYDRA_BANKS],
    output logic [`HYDRA_BANKS-1:0] bank_eop,
    output logic [`HYDRA_BANKS-1:0] busy
);
    import hydra_pkg::*;

    logic [`HYDRA_PORTS-1:0] bound, p_vld, p_eop;
    bank_idx_t bind_bank [`HYDRA_PORTS];
    word_t p_data [`HYDRA_PORTS];
    port_idx_t bank_src [`HYDRA_BANKS];

    for (genvar p = 0; p < `HYDRA_PORTS; p++) begin : g_port
        assign p_vld[p] = xfer[p].vld;
        assign p_data[p] = xfer[p].data;
        assign p_eop[p] = xfer[p].eop;
        assign xfer[p].bank = bind_bank[p];
        assign xfer[p].bound = bound[p];
    end

    // One-hot port select per bank, decoded to the index of the bound port
    always_comb begin
        for (int b = 0; b < `HYDRA_BANKS; b++) begin
            busy[b] = 1'b0;
            bank_src[b] = '0;
            for (int p = 0; p < `HYDRA_PORTS; p++) begin
                if (bound[p] && bind_bank[p] == bank_idx_t'(b)) begin
                    busy[b] = 1'b1;
                    bank_src[b] = port_idx_t'(p);
                end
            end
            bank_vld[b] = busy[b] && p_vld[bank_src[b]];
            bank_data[b] = p_data[bank_src[b]];
            bank_eop[b] = busy[b] && p_eop[bank_src[b]];
        end
    end

    // Lowest-numbered requester wins a free bank
    always_comb begin
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            gnt[p] = req[p] && !busy[req_bank[p]];
            for (int q = 0; q < p; q++) begin
                if (req[q] && req_bank[q] == req_bank[p]) gnt[p] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            if (!rst_n) begin
                bound[p] <= 1'b0;
            end else if (gnt[p]) begin
                bound[p] <= 1'b1;
            end else if (bound[p] && p_vld[p] && p_eop[p]) begin
                bound[p] <= 1'b0;   // Bank frees once the eop word is written
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `HYDRA_PORTS; p++) begin
            if (gnt[p]) bind_bank[p] <= req_bank[p];
        end
    end

endmodule

// ==== source/port_wr_sram_matcher.sv ====
`include "hydra_cfg.svh"

module port_wr_sram_matcher (
    input logic clk,
    input logic rst_n,
    input hydra_pkg::match_mode_t match_mode,
    input hydra_pkg::thresh_t match_threshold,
    input logic match_enable,
    input hydra_pkg::port_idx_t new_dest_port,
    input hydra_pkg::pkt_len_t new_length,
    input hydra_pkg::space_t free_space [`HYDRA_BANKS],
    input logic [`HYDRA_BANKS-1:0] busy,
    input hydra_pkg::pkt_cnt_t dest_cnt [`HYDRA_BANKS][`HYDRA_PORTS],
    output logic req,
    output hydra_pkg::bank_idx_t req_bank,
    input logic gnt,
    output logic match_end
);
    import hydra_pkg::*;

    scan_state_t state;
    bank_idx_t matching_next_sram;
    bank_idx_t matching_best_sram;
    logic found, eligible, mode_better, take;
    space_t cur_free;
    pkt_cnt_t cur_cnt;
    logic [9:0] margin;

    assign cur_free = free_space[matching_next_sram];
    assign cur_cnt = dest_cnt[matching_next_sram][new_dest_port];
    assign margin = {1'b0, cur_free} - {1'b0, new_length};   // Bit 9 flags a packet that does not fit

    assign eligible = !busy[matching_next_sram] && !margin[9]
                      && margin[8:0] >= {4'd0, match_threshold};

    // Strict compares keep ties on the lower bank, since banks are visited in order
    always_comb begin
        case (match_mode)
            MATCH_MOST_FREE: mode_better = cur_free > free_space[matching_best_sram];
            MATCH_FEWEST_DEST: mode_better = cur_cnt < dest_cnt[matching_best_sram][new_dest_port];
            default: mode_better = 1'b0;
        endcase
    end

    assign take = (state == SC_SCAN) && eligible && (!found || mode_better);

    assign req = (state == SC_REQ) && found;
    assign req_bank = matching_best_sram;
    assign match_end = req && gnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SC_IDLE;
            found <= 1'b0;
            matching_next_sram <= '0;
        end else begin
            case (state)
                SC_IDLE: begin
                    found <= 1'b0;
                    matching_next_sram <= '0;
                    if (match_enable) state <= SC_SCAN;
                end
                SC_SCAN: begin
                    if (take) found <= 1'b1;
                    if (matching_next_sram == bank_idx_t'(`HYDRA_BANKS - 1)) begin
                        matching_next_sram <= '0;
                        state <= SC_REQ;
                    end else begin
                        matching_next_sram <= matching_next_sram + 1'b1;
                    end
                end
                SC_REQ: begin
                    found <= 1'b0;
                    state <= match_end ? SC_IDLE : SC_SCAN;   // Lost or empty scan goes again
                end
                default: state <= SC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            matching_best_sram <= matching_next_sram;
        end
    end

endmodule

// ==== source/port_wr_frontend.sv ====
`include "hydra_cfg.svh"

module port_wr_frontend (
    input logic clk,
    input logic rst_n,
    input logic wr_sop,
    input logic wr_eop,
    input logic wr_vld,
    input hydra_pkg::word_t wr_data,
    xfer_if.fe xfer,
    output logic match_enable,
    output hydra_pkg::port_idx_t new_dest_port,
    output hydra_pkg::pkt_len_t new_length,
    input logic match_end,
    output logic fifo_full,
    output logic fifo_afull
);
    import hydra_pkg::*;

    localparam int AW = $clog2(`HYDRA_FIFO_DEPTH);

    logic [17:0] fifo_mem [`HYDRA_FIFO_DEPTH];   // Entry is sop, eop and the word
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0] count;
    fe_state_t state;
    logic push, pop, empty;
    logic head_sop, head_eop;
    word_t head_word;

    assign empty = count == '0;
    assign fifo_full = count == (AW+1)'(`HYDRA_FIFO_DEPTH);
    assign fifo_afull = count >= (AW+1)'(`HYDRA_AFULL_LEVEL);
    assign push = wr_vld && !fifo_full;   // Words arriving while full are lost

    assign {head_sop, head_eop, head_word} = fifo_mem[rd_ptr];
    assign new_length = head_word[15:7];
    assign new_dest_port = head_word[1:0];

    // Raised in the cycle right after the header lands at the FIFO head
    assign match_enable = (state == FE_MATCH) || (state == FE_IDLE && !empty && head_sop);

    assign xfer.vld = (state == FE_XFER) && xfer.bound && !empty;
    assign xfer.data = head_word;
    assign xfer.eop = head_eop;

    // A stray word with no header in front of it is discarded
    assign pop = xfer.vld || (state == FE_IDLE && !empty && !head_sop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FE_IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(push) - (AW+1)'(pop);
            case (state)
                FE_IDLE: if (!empty && head_sop) state <= FE_MATCH;
                FE_MATCH: if (match_end) state <= FE_XFER;
                FE_XFER: if (xfer.vld && head_eop) state <= FE_IDLE;
                default: state <= FE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {wr_sop, wr_eop, wr_data};
        end
    end

endmodule

// ==== source/xfer_if.sv ====
interface xfer_if;
    import hydra_pkg::*;

    logic vld;
    word_t data;
    logic eop;
    bank_idx_t bank;   // Bank the port is bound to
    logic bound;

    modport fe (
        output vld,
        output data,
        output eop,
        input bank,
        input bound
    );

    modport xbar (
        input vld,
        input data,
        input eop,
        output bank,
        output bound
    );

endinterface

// ==== source/hydra_pkg.sv ====
package hydra_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0] port_idx_t;
    typedef logic [2:0] bank_idx_t;
    typedef logic [8:0] pkt_len_t;   // Header bits 15 to 7
    typedef logic [8:0] space_t;     // Holds a full bank of 256 words
    typedef logic [7:0] bank_addr_t;
    typedef logic [8:0] pkt_cnt_t;
    typedef logic [4:0] thresh_t;

    typedef enum logic [1:0] {
        MATCH_FIRST_FIT,
        MATCH_MOST_FREE,
        MATCH_FEWEST_DEST
    } match_mode_t;

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_MATCH,
        FE_XFER
    } fe_state_t;

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_SCAN,
        SC_REQ
    } scan_state_t;

endpackage

// ==== source/hydra_cfg.svh ====
`ifndef HYDRA_CFG_SVH
`define HYDRA_CFG_SVH

// Ingress ports and shared SRAM banks
`define HYDRA_PORTS 4
`define HYDRA_BANKS 8

// Words per bank
`define HYDRA_BANK_WORDS 256

// Per-port ingress FIFO depth in words
`define HYDRA_FIFO_DEPTH 64

// Fill level that raises almost_full
`define HYDRA_AFULL_LEVEL 48

`endif
